//--- riscv_decode_pkg.sv
package riscv_decode_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // executor operation selector
  typedef logic [4:0] op_code_t;

  // branch condition, same encoding as funct3
  typedef logic [2:0] branch_kind_t;

  localparam op_code_t OP_NOP  = 5'd0;
  localparam op_code_t OP_ADD  = 5'd1;
  localparam op_code_t OP_SUB  = 5'd2;
  localparam op_code_t OP_XOR  = 5'd3;
  localparam op_code_t OP_OR   = 5'd4;
  localparam op_code_t OP_AND  = 5'd5;
  localparam op_code_t OP_SLL  = 5'd6;
  localparam op_code_t OP_SLT  = 5'd7;
  localparam op_code_t OP_SLTU = 5'd8;
  localparam op_code_t OP_SRL  = 5'd9;
  localparam op_code_t OP_SRA  = 5'd10;
  localparam op_code_t OP_LB   = 5'd11;
  localparam op_code_t OP_LH   = 5'd12;
  localparam op_code_t OP_LW   = 5'd13;
  localparam op_code_t OP_LBU  = 5'd14;
  localparam op_code_t OP_LHU  = 5'd15;
  localparam op_code_t OP_SB   = 5'd16;
  localparam op_code_t OP_SH   = 5'd17;
  localparam op_code_t OP_SW   = 5'd18;

  // major opcodes, instruction bits 6:2
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_OP_IMM = 5'b00100;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;

  // funct7 values used by RV32I
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // branch conditions
  localparam branch_kind_t BR_EQ  = 3'b000;
  localparam branch_kind_t BR_NE  = 3'b001;
  localparam branch_kind_t BR_LT  = 3'b100;
  localparam branch_kind_t BR_GE  = 3'b101;
  localparam branch_kind_t BR_LTU = 3'b110;
  localparam branch_kind_t BR_GEU = 3'b111;

  // load and store widths, funct3
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_HALF   = 3'b001;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;
  localparam logic [2:0] F3_HALF_U = 3'b101;

  // alu funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

endpackage

//--- instr_decode_stage.sv
module instr_decode_stage import riscv_decode_pkg::*; (
  input  var logic         clk,
  input  var logic         reset,
  input  var logic         in_valid,
  input  var word_t        in_instr,
  input  var word_t        in_pc,
  output var reg_addr_t    rs1,
  output var reg_addr_t    rs2,
  input  var word_t        reg_rs1,
  input  var word_t        reg_rs2,
  output var logic         d_valid,
  output var op_code_t     d_op,
  output var reg_addr_t    d_rd,
  output var word_t        d_imm,
  output var word_t        d_pc,
  output var word_t        d_rs1_val,
  output var word_t        d_rs2_val,
  output var logic         d_is_branch,
  output var logic         d_is_jal,
  output var logic         d_is_jalr,
  output var logic         d_is_auipc,
  output var logic         d_is_lui,
  output var logic         d_use_imm,
  output var branch_kind_t d_branch_kind,
  output var logic         d_illegal
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      i_imm, s_imm, b_imm, u_imm, j_imm;
  word_t      imm;
  op_code_t   op, alu_op;
  logic       legal, is_store;
  logic       is_branch, is_jal, is_jalr, is_auipc, is_lui, use_imm;
  reg_addr_t  rd;

  assign opcode = in_instr[6:2];
  assign funct3 = in_instr[14:12];
  assign funct7 = in_instr[31:25];

  // register file is read in the same cycle
  assign rs1 = in_instr[19:15];
  assign rs2 = in_instr[24:20];

  assign i_imm = {{20{in_instr[31]}}, in_instr[31:20]};
  assign s_imm = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
  assign b_imm = {{20{in_instr[31]}}, in_instr[7], in_instr[30:25], in_instr[11:8], 1'b0};
  assign u_imm = {in_instr[31:12], 12'b0};
  assign j_imm = {{12{in_instr[31]}}, in_instr[19:12], in_instr[20], in_instr[30:21], 1'b0};

  // shared by OP and OP-IMM, sub only exists in register form
  always_comb begin
    case (funct3)
      F3_ADD:  alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ? OP_SUB : OP_ADD;
      F3_SLL:  alu_op = OP_SLL;
      F3_SLT:  alu_op = OP_SLT;
      F3_SLTU: alu_op = OP_SLTU;
      F3_XOR:  alu_op = OP_XOR;
      F3_SR:   alu_op = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
      F3_OR:   alu_op = OP_OR;
      default: alu_op = OP_AND;
    endcase
  end

  always_comb begin
    op        = OP_NOP;
    imm       = '0;
    legal     = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_auipc  = 1'b0;
    is_lui    = 1'b0;
    use_imm   = 1'b0;
    // anything not 32 bits wide stays illegal
    if (in_instr[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI: begin
          legal  = 1'b1;
          is_lui = 1'b1;
          imm    = u_imm;
        end
        OPC_AUIPC: begin
          legal    = 1'b1;
          is_auipc = 1'b1;
          imm      = u_imm;
        end
        OPC_JAL: begin
          legal  = 1'b1;
          is_jal = 1'b1;
          imm    = j_imm;
        end
        OPC_JALR: begin
          legal   = (funct3 == 3'b000);
          is_jalr = legal;
          imm     = i_imm;
        end
        OPC_BRANCH: begin
          legal     = (funct3 != 3'b010) && (funct3 != 3'b011);
          is_branch = legal;
          imm       = b_imm;
        end
        OPC_LOAD: begin
          imm   = i_imm;
          legal = 1'b1;
          case (funct3)
            F3_BYTE:   op = OP_LB;
            F3_HALF:   op = OP_LH;
            F3_WORD:   op = OP_LW;
            F3_BYTE_U: op = OP_LBU;
            F3_HALF_U: op = OP_LHU;
            default:   legal = 1'b0;
          endcase
        end
        OPC_STORE: begin
          imm      = s_imm;
          legal    = 1'b1;
          is_store = 1'b1;
          case (funct3)
            F3_BYTE: op = OP_SB;
            F3_HALF: op = OP_SH;
            F3_WORD: op = OP_SW;
            default: legal = 1'b0;
          endcase
        end
        OPC_OP_IMM: begin
          imm = i_imm;
          if (funct3 == F3_SLL) legal = (funct7 == F7_BASE);
          else if (funct3 == F3_SR) legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          else legal = 1'b1;
          use_imm = legal;
          op      = legal ? alu_op : OP_NOP;
        end
        OPC_OP: begin
          // M extension (funct7 0000001) falls out here
          legal = (funct7 == F7_BASE) ||
                  (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
          op    = legal ? alu_op : OP_NOP;
        end
        default: legal = 1'b0;
      endcase
    end
    if (!legal) op = OP_NOP;
  end

  assign rd = (!legal || is_branch || is_store) ? '0 : in_instr[11:7];

  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      d_op          <= op;
      d_rd          <= rd;
      d_imm         <= imm;
      d_pc          <= in_pc;
      d_rs1_val     <= reg_rs1;
      d_rs2_val     <= reg_rs2;
      d_is_branch   <= is_branch;
      d_is_jal      <= is_jal;
      d_is_jalr     <= is_jalr;
      d_is_auipc    <= is_auipc;
      d_is_lui      <= is_lui;
      d_use_imm     <= use_imm;
      d_branch_kind <= branch_kind_t'(funct3);
      d_illegal     <= !legal;
    end
  end

  // operand stage relies on a single class per record
  a_one_class: assert property (@(posedge clk) disable iff (reset)
    d_valid |-> $onehot0({d_is_branch, d_is_jal, d_is_jalr, d_is_auipc, d_is_lui, d_use_imm}));

endmodule

//--- operand_stage.sv
module operand_stage import riscv_decode_pkg::*; (
  input  var logic         clk,
  input  var logic         reset,
  input  var logic         d_valid,
  input  var op_code_t     d_op,
  input  var reg_addr_t    d_rd,
  input  var word_t        d_imm,
  input  var word_t        d_pc,
  input  var word_t        d_rs1_val,
  input  var word_t        d_rs2_val,
  input  var logic         d_is_branch,
  input  var logic         d_is_jal,
  input  var logic         d_is_jalr,
  input  var logic         d_is_auipc,
  input  var logic         d_is_lui,
  input  var logic         d_use_imm,
  input  var branch_kind_t d_branch_kind,
  input  var logic         d_illegal,
  output var logic         e_valid,
  output var op_code_t     e_op,
  output var reg_addr_t    e_rd,
  output var word_t        e_operand_a,
  output var word_t        e_operand_b,
  output var word_t        e_mem_addr,
  output var word_t        e_store_data,
  output var word_t        e_next_pc,
  output var logic         e_illegal
);

  word_t    operand_a, operand_b;
  word_t    rs1_plus_imm, pc_plus_imm, pc_plus_4;
  word_t    next_pc;
  op_code_t op;
  logic     taken;

  assign rs1_plus_imm = d_rs1_val + d_imm;
  assign pc_plus_imm  = d_pc + d_imm;
  assign pc_plus_4    = d_pc + 32'd4;

  always_comb begin
    case (d_branch_kind)
      BR_EQ:   taken = (d_rs1_val == d_rs2_val);
      BR_NE:   taken = (d_rs1_val != d_rs2_val);
      BR_LT:   taken = ($signed(d_rs1_val) < $signed(d_rs2_val));
      BR_GE:   taken = ($signed(d_rs1_val) >= $signed(d_rs2_val));
      BR_LTU:  taken = (d_rs1_val < d_rs2_val);
      BR_GEU:  taken = (d_rs1_val >= d_rs2_val);
      default: taken = 1'b0;
    endcase
  end

  // link and pc-relative forms become pc + something
  always_comb begin
    if (d_is_jal || d_is_jalr || d_is_auipc) operand_a = d_pc;
    else if (d_is_lui) operand_a = '0;
    else operand_a = d_rs1_val;
  end

  always_comb begin
    if (d_use_imm || d_is_lui || d_is_auipc) operand_b = d_imm;
    else if (d_is_jal || d_is_jalr) operand_b = 32'd4;
    else operand_b = d_rs2_val;
  end

  always_comb begin
    if (d_is_branch && taken) next_pc = pc_plus_imm;
    else if (d_is_jal) next_pc = pc_plus_imm;
    else if (d_is_jalr) next_pc = {rs1_plus_imm[31:1], 1'b0};
    else next_pc = pc_plus_4;
  end

  always_comb begin
    if (d_is_jal || d_is_jalr || d_is_lui || d_is_auipc) op = OP_ADD;
    else if (d_is_branch) op = OP_NOP;
    else op = d_op;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid) begin
      e_op         <= op;
      e_rd         <= d_rd;
      e_operand_a  <= operand_a;
      e_operand_b  <= operand_b;
      e_mem_addr   <= rs1_plus_imm;
      e_store_data <= d_rs2_val;
      e_next_pc    <= next_pc;
      e_illegal    <= d_illegal;
    end
  end

endmodule

//--- issue_queue.sv
module issue_queue import riscv_decode_pkg::*; #(
  parameter int QUEUE_DEPTH  = 4,
  parameter int EXEC_CREDITS = 2
) (
  input  var logic      clk,
  input  var logic      reset,
  input  var logic      push,
  input  var op_code_t  e_op,
  input  var reg_addr_t e_rd,
  input  var word_t     e_operand_a,
  input  var word_t     e_operand_b,
  input  var word_t     e_mem_addr,
  input  var word_t     e_store_data,
  input  var word_t     e_next_pc,
  input  var logic      e_illegal,
  output var logic      out_valid,
  output var op_code_t  out_op,
  output var reg_addr_t out_rd,
  output var word_t     out_operand_a,
  output var word_t     out_operand_b,
  output var word_t     out_mem_addr,
  output var word_t     out_store_data,
  output var word_t     out_next_pc,
  output var logic      out_illegal,
  output var logic      in_credit,
  input  var logic      out_credit
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(EXEC_CREDITS + 1);

  op_code_t   q_op         [QUEUE_DEPTH];
  reg_addr_t  q_rd         [QUEUE_DEPTH];
  word_t      q_operand_a  [QUEUE_DEPTH];
  word_t      q_operand_b  [QUEUE_DEPTH];
  word_t      q_mem_addr   [QUEUE_DEPTH];
  word_t      q_store_data [QUEUE_DEPTH];
  word_t      q_next_pc    [QUEUE_DEPTH];
  logic       q_illegal    [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             pop;

  // pop needs a record and an executor credit
  assign pop       = (count != '0) && (credits != '0);
  assign out_valid = pop;
  assign in_credit = pop;

  assign out_op         = q_op[rd_ptr];
  assign out_rd         = q_rd[rd_ptr];
  assign out_operand_a  = q_operand_a[rd_ptr];
  assign out_operand_b  = q_operand_b[rd_ptr];
  assign out_mem_addr   = q_mem_addr[rd_ptr];
  assign out_store_data = q_store_data[rd_ptr];
  assign out_next_pc    = q_next_pc[rd_ptr];
  assign out_illegal    = q_illegal[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      q_op[wr_ptr]         <= e_op;
      q_rd[wr_ptr]         <= e_rd;
      q_operand_a[wr_ptr]  <= e_operand_a;
      q_operand_b[wr_ptr]  <= e_operand_b;
      q_mem_addr[wr_ptr]   <= e_mem_addr;
      q_store_data[wr_ptr] <= e_store_data;
      q_next_pc[wr_ptr]    <= e_next_pc;
      q_illegal[wr_ptr]    <= e_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(EXEC_CREDITS);
    end else begin
      // pointers wrap explicitly so any depth works
      if (push) wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      case ({pop, out_credit})
        2'b10:   credits <= credits - CRD_W'(1);
        2'b01:   credits <= credits + CRD_W'(1);
        default: credits <= credits;
      endcase
    end
  end

  // fetcher credits must keep the stages from overrunning the buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(push && count == CNT_W'(QUEUE_DEPTH)));

  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= CRD_W'(EXEC_CREDITS));

endmodule

//--- decoder_top.sv
module decoder_top import riscv_decode_pkg::*; #(
  parameter int QUEUE_DEPTH  = 4,
  parameter int EXEC_CREDITS = 2
) (
  input  var logic      clk,
  input  var logic      reset,
  input  var logic      in_valid,
  input  var word_t     in_instr,
  input  var word_t     in_pc,
  output var logic      in_credit,
  output var reg_addr_t rs1,
  output var reg_addr_t rs2,
  input  var word_t     reg_rs1,
  input  var word_t     reg_rs2,
  output var logic      out_valid,
  output var op_code_t  out_op,
  output var reg_addr_t out_rd,
  output var word_t     out_operand_a,
  output var word_t     out_operand_b,
  output var word_t     out_mem_addr,
  output var word_t     out_store_data,
  output var word_t     out_next_pc,
  output var logic      out_illegal,
  input  var logic      out_credit
);

  logic         d_valid, d_illegal;
  op_code_t     d_op;
  reg_addr_t    d_rd;
  word_t        d_imm, d_pc, d_rs1_val, d_rs2_val;
  logic         d_is_branch, d_is_jal, d_is_jalr, d_is_auipc, d_is_lui, d_use_imm;
  branch_kind_t d_branch_kind;

  logic         e_valid, e_illegal;
  op_code_t     e_op;
  reg_addr_t    e_rd;
  word_t        e_operand_a, e_operand_b, e_mem_addr, e_store_data, e_next_pc;

  instr_decode_stage u_decode (
    .clk, .reset, .in_valid, .in_instr, .in_pc, .rs1, .rs2, .reg_rs1, .reg_rs2,
    .d_valid, .d_op, .d_rd, .d_imm, .d_pc, .d_rs1_val, .d_rs2_val,
    .d_is_branch, .d_is_jal, .d_is_jalr, .d_is_auipc, .d_is_lui, .d_use_imm,
    .d_branch_kind, .d_illegal
  );

  operand_stage u_operand (
    .clk, .reset,
    .d_valid, .d_op, .d_rd, .d_imm, .d_pc, .d_rs1_val, .d_rs2_val,
    .d_is_branch, .d_is_jal, .d_is_jalr, .d_is_auipc, .d_is_lui, .d_use_imm,
    .d_branch_kind, .d_illegal,
    .e_valid, .e_op, .e_rd, .e_operand_a, .e_operand_b, .e_mem_addr,
    .e_store_data, .e_next_pc, .e_illegal
  );

  // every stage 2 record lands in the queue
  issue_queue #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .EXEC_CREDITS (EXEC_CREDITS)
  ) u_queue (
    .clk, .reset,
    .push (e_valid),
    .e_op, .e_rd, .e_operand_a, .e_operand_b, .e_mem_addr, .e_store_data,
    .e_next_pc, .e_illegal,
    .out_valid, .out_op, .out_rd, .out_operand_a, .out_operand_b, .out_mem_addr,
    .out_store_data, .out_next_pc, .out_illegal,
    .in_credit, .out_credit
  );

endmodule

//--- tb_decoder.sv
module tb_decoder import riscv_decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int QUEUE_DEPTH  = 4;
  localparam int EXEC_CREDITS = 2;
  localparam int TIMEOUT      = 50;

  localparam int M_OPND = 1;
  localparam int M_MEM  = 2;
  localparam int M_SD   = 4;
  localparam int M_NPC  = 8;

  // rv32i major opcodes, full 7 bits
  localparam int OPC7_LOAD   = 'h03;
  localparam int OPC7_OP_IMM = 'h13;
  localparam int OPC7_AUIPC  = 'h17;
  localparam int OPC7_OP     = 'h33;
  localparam int OPC7_LUI    = 'h37;
  localparam int OPC7_JALR   = 'h67;
  localparam int OPC7_SYSTEM = 'h73;

  typedef struct packed {
    op_code_t  op;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     mem;
    word_t     sd;
    word_t     npc;
    logic      ill;
  } rec_t;

  logic      clk, reset;
  logic      in_valid, in_credit, out_valid, out_illegal, out_credit;
  word_t     in_instr, in_pc, reg_rs1, reg_rs2;
  reg_addr_t rs1, rs2, out_rd;
  op_code_t  out_op;
  word_t     out_operand_a, out_operand_b, out_mem_addr, out_store_data, out_next_pc;

  rec_t  rec_q[$];
  rec_t  exp_q[$];
  int    mask_q[$];
  string name_q[$];

  int    errors = 0;
  int    checks = 0;
  int    passed = 0;
  int    failed = 0;
  int    sent_count = 0;
  int    in_credit_count = 0;
  int    owed = 0;
  logic  credit_next = 1'b0;
  logic  hold_credits = 1'b0;
  logic  random_credits = 1'b0;
  word_t stim_state = 32'd22;
  word_t credit_state = 32'd22;

  decoder_top #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .EXEC_CREDITS (EXEC_CREDITS)
  ) UUT (
    .clk, .reset, .in_valid, .in_instr, .in_pc, .in_credit, .rs1, .rs2,
    .reg_rs1, .reg_rs2, .out_valid, .out_op, .out_rd, .out_operand_a,
    .out_operand_b, .out_mem_addr, .out_store_data, .out_next_pc,
    .out_illegal, .out_credit
  );

  function automatic word_t reg_value(input reg_addr_t r);
    return (r == 5'd0) ? 32'h0 : word_t'(r) * 32'h01010101;
  endfunction

  function automatic word_t rv(input int r);
    return reg_value(r[4:0]);
  endfunction

  // register file answers in the same cycle
  assign reg_rs1 = reg_value(rs1);
  assign reg_rs2 = reg_value(rs2);

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t enc_r(input int f7, input int r2, input int r1, input int f3,
                                  input int rd, input int opc);
    return {f7[6:0], r2[4:0], r1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t enc_i(input int imm, input int r1, input int f3, input int rd,
                                  input int opc);
    return {imm[11:0], r1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t enc_s(input int imm, input int r2, input int r1, input int f3);
    return {imm[11:5], r2[4:0], r1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input int imm, input int r2, input int r1, input int f3);
    return {imm[12], imm[10:5], r2[4:0], r1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(input int imm, input int rd, input int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic word_t sext12(input int v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  function automatic word_t sext13(input int v);
    return {{19{v[12]}}, v[12:0]};
  endfunction

  function automatic word_t sext21(input int v);
    return {{11{v[20]}}, v[20:0]};
  endfunction

  function automatic rec_t make_rec(input op_code_t op, input int rd, input word_t a,
                                    input word_t b, input word_t mem, input word_t sd,
                                    input word_t npc, input logic ill);
    rec_t r;
    r.op  = op;
    r.rd  = rd[4:0];
    r.a   = a;
    r.b   = b;
    r.mem = mem;
    r.sd  = sd;
    r.npc = npc;
    r.ill = ill;
    return r;
  endfunction

  // rv32i register-register op selection
  function automatic op_code_t expected_alu_op(input int f3, input logic alt);
    case (f3)
      0:       return alt ? OP_SUB : OP_ADD;
      1:       return OP_SLL;
      2:       return OP_SLT;
      3:       return OP_SLTU;
      4:       return OP_XOR;
      5:       return alt ? OP_SRA : OP_SRL;
      6:       return OP_OR;
      default: return OP_AND;
    endcase
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // collects records, counts credits and decides the executor's credit return
  always @(negedge clk) begin : monitor
    rec_t r;
    logic give;
    if (!reset) begin
      if (out_valid) begin
        r.op  = out_op;
        r.rd  = out_rd;
        r.a   = out_operand_a;
        r.b   = out_operand_b;
        r.mem = out_mem_addr;
        r.sd  = out_store_data;
        r.npc = out_next_pc;
        r.ill = out_illegal;
        rec_q.push_back(r);
        owed = owed + 1;
      end
      if (in_credit) in_credit_count = in_credit_count + 1;
      give = !hold_credits && owed > 0;
      if (give && random_credits) begin
        credit_state = lcg_next(credit_state);
        give = credit_state[30];
      end
      if (give) owed = owed - 1;
      credit_next = give;
    end
  end

  always @(posedge clk) begin
    #1;
    out_credit = credit_next;
  end

  initial begin
    #500000;
    $display("global timeout, simulation stopped");
    $display("sim failed");
    $finish;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input op_code_t exp, input op_code_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic send_instr(input word_t instr, input word_t pc);
    int waited;
    waited = 0;
    while (QUEUE_DEPTH + in_credit_count - sent_count == 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (QUEUE_DEPTH + in_credit_count - sent_count == 0) begin
      errors++;
      $display("no fetch credit came back within %0d cycles", TIMEOUT);
    end else begin
      in_valid   = 1'b1;
      in_instr   = instr;
      in_pc      = pc;
      sent_count = sent_count + 1;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic issue(input string name, input word_t instr, input word_t pc,
                       input rec_t exp, input int mask);
    send_instr(instr, pc);
    exp_q.push_back(exp);
    mask_q.push_back(mask);
    name_q.push_back(name);
  endtask

  task automatic compare_record(input string name, input rec_t exp, input rec_t act,
                                input int mask);
    check_op({name, " op"}, exp.op, act.op);
    check_reg({name, " rd"}, exp.rd, act.rd);
    check_bit({name, " illegal"}, exp.ill, act.ill);
    if ((mask & M_OPND) != 0) begin
      check_word({name, " operand a"}, exp.a, act.a);
      check_word({name, " operand b"}, exp.b, act.b);
    end
    if ((mask & M_MEM) != 0) check_word({name, " mem addr"}, exp.mem, act.mem);
    if ((mask & M_SD) != 0) check_word({name, " store data"}, exp.sd, act.sd);
    if ((mask & M_NPC) != 0) check_word({name, " next pc"}, exp.npc, act.npc);
  endtask

  // pops expected records in order and matches each against the next output
  task automatic drain();
    rec_t  exp;
    rec_t  act;
    int    mask;
    string name;
    int    waited;
    while (exp_q.size() > 0) begin
      exp    = exp_q.pop_front();
      mask   = mask_q.pop_front();
      name   = name_q.pop_front();
      waited = 0;
      while (rec_q.size() == 0 && waited < TIMEOUT) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (rec_q.size() == 0) begin
        errors++;
        $display("%s: no record came out within %0d cycles", name, TIMEOUT);
      end else begin
        act = rec_q.pop_front();
        compare_record(name, exp, act, mask);
      end
    end
  endtask

  task automatic settle();
    int waited;
    waited = 0;
    while ((owed != 0 || QUEUE_DEPTH + in_credit_count - sent_count != QUEUE_DEPTH)
           && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (owed != 0 || QUEUE_DEPTH + in_credit_count - sent_count != QUEUE_DEPTH) begin
      errors++;
      $display("credits did not return to their reset values within %0d cycles", TIMEOUT);
    end
    check_word("extra records", 32'h0, word_t'(rec_q.size()));
  endtask

  task automatic finish_test(input string name, input int err0);
    if (errors == err0) begin
      passed++;
      $display("PASS %s", name);
    end else begin
      failed++;
      $display("FAIL %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_alu();
    int    err0;
    word_t pc;
    err0 = errors;
    pc   = 32'h1000;
    check_bit("reset out_valid", 1'b0, out_valid);
    check_bit("reset in_credit", 1'b0, in_credit);
    issue("add", enc_r(0, 2, 1, 0, 3, OPC7_OP), pc,
          make_rec(OP_ADD, 3, rv(1), rv(2), 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("sub", enc_r('h20, 7, 6, 0, 5, OPC7_OP), pc,
          make_rec(OP_SUB, 5, rv(6), rv(7), 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("xor", enc_r(0, 10, 9, 4, 8, OPC7_OP), pc,
          make_rec(OP_XOR, 8, rv(9), rv(10), 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("sra", enc_r('h20, 13, 12, 5, 11, OPC7_OP), pc,
          make_rec(OP_SRA, 11, rv(12), rv(13), 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("addi", enc_i(-5, 15, 0, 14, OPC7_OP_IMM), pc,
          make_rec(OP_ADD, 14, rv(15), sext12(-5), 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("slli", enc_i(7, 17, 1, 16, OPC7_OP_IMM), pc,
          make_rec(OP_SLL, 16, rv(17), 32'd7, 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("sltiu", enc_i('h7ff, 19, 3, 18, OPC7_OP_IMM), pc,
          make_rec(OP_SLTU, 18, rv(19), 32'h7ff, 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    drain();
    settle();
    finish_test("alu decode", err0);
  endtask

  task automatic test_mem();
    int    err0;
    word_t pc;
    err0 = errors;
    pc   = 32'h2000;
    issue("lw", enc_i(-8, 2, 2, 4, OPC7_LOAD), pc,
          make_rec(OP_LW, 4, 0, 0, rv(2) + sext12(-8), 0, pc + 32'd4, 1'b0), M_MEM | M_NPC);
    pc = pc + 32'd4;
    issue("lbu", enc_i('h123, 3, 4, 6, OPC7_LOAD), pc,
          make_rec(OP_LBU, 6, 0, 0, rv(3) + 32'h123, 0, pc + 32'd4, 1'b0), M_MEM | M_NPC);
    pc = pc + 32'd4;
    issue("sh", enc_s(-2, 7, 9, 1), pc,
          make_rec(OP_SH, 0, 0, 0, rv(9) + sext12(-2), rv(7), pc + 32'd4, 1'b0),
          M_MEM | M_SD | M_NPC);
    pc = pc + 32'd4;
    issue("sb", enc_s('h45, 1, 0, 0), pc,
          make_rec(OP_SB, 0, 0, 0, 32'h45, rv(1), pc + 32'd4, 1'b0), M_MEM | M_SD | M_NPC);
    drain();
    settle();
    finish_test("loads and stores", err0);
  endtask

  task automatic branch_case(input string name, input int f3, input int r1, input int r2,
                             input int off, input logic taken, input word_t pc);
    word_t npc;
    npc = taken ? pc + sext13(off) : pc + 32'd4;
    issue(name, enc_b(off, r2, r1, f3), pc, make_rec(OP_NOP, 0, 0, 0, 0, 0, npc, 1'b0), M_NPC);
  endtask

  task automatic test_control();
    int    err0;
    word_t pc;
    err0 = errors;
    pc   = 32'h3000;
    branch_case("beq taken", 0, 5, 5, 16, 1'b1, pc);
    branch_case("beq not taken", 0, 5, 6, 16, 1'b0, pc + 32'd4);
    branch_case("bne taken", 1, 5, 6, -32, 1'b1, pc + 32'd8);
    branch_case("bne not taken", 1, 3, 3, -32, 1'b0, pc + 32'd12);
    branch_case("blt taken", 4, 0, 4, 'h100, 1'b1, pc + 32'd16);
    branch_case("blt not taken", 4, 4, 0, 'h100, 1'b0, pc + 32'd20);
    branch_case("bgeu taken", 7, 4, 2, -4, 1'b1, pc + 32'd24);
    branch_case("bgeu not taken", 7, 2, 4, -4, 1'b0, pc + 32'd28);
    pc = pc + 32'd32;
    issue("jal", enc_j('h800, 1), pc,
          make_rec(OP_ADD, 1, pc, 32'd4, 0, 0, pc + sext21('h800), 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("jalr", enc_i('h14, 3, 0, 5, OPC7_JALR), pc,
          make_rec(OP_ADD, 5, pc, 32'd4, 0, 0, (rv(3) + 32'h14) & ~32'h1, 1'b0),
          M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("lui", enc_u('habcde, 7, OPC7_LUI), pc,
          make_rec(OP_ADD, 7, 32'h0, 32'habcde000, 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    pc = pc + 32'd4;
    issue("auipc", enc_u('h12345, 9, OPC7_AUIPC), pc,
          make_rec(OP_ADD, 9, pc, 32'h12345000, 0, 0, pc + 32'd4, 1'b0), M_OPND | M_NPC);
    drain();
    settle();
    finish_test("control flow", err0);
  endtask

  task automatic test_illegal();
    int    err0;
    word_t pc;
    rec_t  bad;
    err0 = errors;
    pc   = 32'h4000;
    bad  = make_rec(OP_NOP, 0, 0, 0, 0, 0, 0, 1'b1);
    issue("ecall", 32'h00000073, pc, bad, 0);
    issue("mul", enc_r(1, 2, 1, 0, 3, OPC7_OP), pc + 32'd4, bad, 0);
    issue("csrrw", enc_i('h300, 2, 1, 1, OPC7_SYSTEM), pc + 32'd8, bad, 0);
    issue("compressed", 32'h00004501, pc + 32'd12, bad, 0);
    drain();
    settle();
    finish_test("illegal encodings", err0);
  endtask

  task automatic test_backpressure();
    int    err0;
    int    snap;
    int    i;
    int    imm;
    word_t pc;
    err0 = errors;
    pc   = 32'h5000;
    hold_credits = 1'b1;
    for (i = 0; i < EXEC_CREDITS + QUEUE_DEPTH; i++) begin
      imm = 16 * i + 3;
      issue($sformatf("hold %0d", i), enc_i(imm, 0, 0, i + 1, OPC7_OP_IMM), pc,
            make_rec(OP_ADD, i + 1, 32'h0, sext12(imm), 0, 0, pc + 32'd4, 1'b0),
            M_OPND | M_NPC);
      pc = pc + 32'd4;
    end
    snap = in_credit_count;
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    check_word("records during hold", word_t'(EXEC_CREDITS), word_t'(rec_q.size()));
    check_bit("in_credit during hold", 1'b0, in_credit_count != snap);
    check_word("fetch credits during hold", 32'h0,
               word_t'(QUEUE_DEPTH + in_credit_count - sent_count));
    hold_credits = 1'b0;
    drain();
    settle();
    finish_test("back-pressure", err0);
  endtask

  task automatic test_random();
    int    err0;
    int    i;
    int    f3;
    int    rd;
    int    r1;
    int    r2;
    logic  alt;
    word_t pc;
    err0 = errors;
    pc   = 32'h6000;
    random_credits = 1'b1;
    for (i = 0; i < 40; i++) begin
      stim_state = lcg_next(stim_state);
      f3  = int'(stim_state[30:28]);
      alt = stim_state[27] && (f3 == 0 || f3 == 5);
      rd  = int'(stim_state[26:22]);
      r1  = int'(stim_state[21:17]);
      r2  = int'(stim_state[16:12]);
      issue($sformatf("random %0d", i), enc_r(alt ? 'h20 : 0, r2, r1, f3, rd, OPC7_OP), pc,
            make_rec(expected_alu_op(f3, alt), rd, rv(r1), rv(r2), 0, 0, pc + 32'd4, 1'b0),
            M_OPND | M_NPC);
      pc = pc + 32'd4;
    end
    drain();
    random_credits = 1'b0;
    settle();
    finish_test("random stream", err0);
  endtask

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_instr = 32'h0;
    in_pc    = 32'h0;
    out_credit = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_alu();
    test_mem();
    test_control();
    test_illegal();
    test_backpressure();
    test_random();
    $display("tests %0d passed, %0d failed; %0d checks, %0d errors",
             passed, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- compile.f
riscv_decode_pkg.sv
instr_decode_stage.sv
operand_stage.sv
issue_queue.sv
decoder_top.sv
tb_decoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decoder
FLAGS     ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove obj_dir"
	@echo "variables: VERILATOR=$(VERILATOR) TOP=$(TOP) FLAGS=$(FLAGS)"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
